//--- src/pip_types_pkg.sv
`default_nettype none

package pip_types_pkg;

  typedef enum logic [1:0] {
    FWD_NONE            = 2'd0,
    FWD_FROM_EXMEM      = 2'd1,
    FWD_FROM_MEMWB      = 2'd2,
    FWD_FROM_MEMWB_LATE = 2'd3  // b is only needed in mem
  } fwd_t;

  typedef enum logic [3:0] {
    OP_PASS_A = 4'd0,
    OP_ADD    = 4'd1,
    OP_SUB    = 4'd2,
    OP_AND    = 4'd3,
    OP_OR     = 4'd4,
    OP_XOR    = 4'd5,
    OP_NOR    = 4'd6,
    OP_SLL    = 4'd7,
    OP_SRL    = 4'd8,
    OP_SRA    = 4'd9,
    OP_LUI    = 4'd10
  } alu_op_t;

  typedef enum logic {
    RES_ALU = 1'b0,
    RES_SET = 1'b1  // slt style result
  } alu_res_t;

  typedef enum logic [1:0] {
    OP_LS_BYTE     = 2'd0,
    OP_LS_HALFWORD = 2'd1,
    OP_LS_WORD     = 2'd2
  } ls_op_t;

  typedef enum logic [2:0] {
    COND_UNCONDITIONAL = 3'd0,
    COND_EQ            = 3'd1,
    COND_NE            = 3'd2,
    COND_LE            = 3'd3,
    COND_GT            = 3'd4
  } cond_t;

  typedef struct packed {
    logic [5:0] opc;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  opc;
    logic [25:0] addr26;
  } j_fmt_t;

  // one instruction word, three views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } inst_word_t;

  typedef struct packed {
    logic [4:0]  a_reg;
    logic        a_reg_valid;
    logic [4:0]  b_reg;
    logic        b_reg_valid;
    logic        b_need_late;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
    logic [31:0] imm;  // already extended
    logic        imm_valid;
    logic [4:0]  shamt;
    alu_op_t     alu_op;
    alu_res_t    alu_res_sel;
    logic        alu_set_u;
    ls_op_t      ls_op;
    logic        ls_sext;
    cond_t       jmp_cond;
    logic        alu_inst;
    logic        load_inst;
    logic        store_inst;
    logic        jmp_inst;
    logic        illegal_inst;
  } decode_t;

  typedef struct packed {
    fwd_t a_fwd;
    fwd_t b_fwd;
  } fwd_sel_t;

  typedef struct packed {
    logic [4:0] reg_num;
    logic       valid;
  } dest_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] a_data;
    logic [31:0] b_data;
    logic [4:0]  a_reg;
    logic [4:0]  b_reg;
    logic        b_need_late;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
    logic [31:0] imm;
    logic        imm_valid;
    logic [4:0]  shamt;
    alu_op_t     alu_op;
    alu_res_t    alu_res_sel;
    logic        alu_set_u;
    ls_op_t      ls_op;
    logic        ls_sext;
    cond_t       jmp_cond;
    logic        alu_inst;
    logic        load_inst;
    logic        store_inst;
    logic        jmp_inst;
    fwd_sel_t    fwd;
  } id_ex_t;

endpackage

`default_nettype wire

//--- src/inst_decoder.sv
`default_nettype none

module inst_decoder import pip_types_pkg::*; (
  input  inst_word_t inst,
  output decode_t    dec
);

  logic imm_sext;
  logic i_format;

  always_comb begin
    dec                = '0;
    dec.a_reg          = inst.r_fmt.rs;
    dec.b_reg          = inst.r_fmt.rt;
    dec.dest_reg       = inst.r_fmt.rt;
    dec.dest_reg_valid = 1'b1;
    dec.alu_op         = OP_PASS_A;
    dec.alu_res_sel    = RES_ALU;
    dec.ls_op          = OP_LS_WORD;
    dec.jmp_cond       = COND_UNCONDITIONAL;
    imm_sext           = 1'b0;
    i_format           = 1'b1;

    case (inst.j_fmt.opc)
      6'h00: begin
        i_format        = 1'b0;
        dec.dest_reg    = inst.r_fmt.rd;
        dec.shamt       = inst.r_fmt.shamt;
        dec.alu_inst    = 1'b1;  // most functs are alu ops on rs, rt
        dec.a_reg_valid = 1'b1;
        dec.b_reg_valid = 1'b1;
        case (inst.r_fmt.funct)
          6'd0: begin  // sll
            dec.alu_op      = OP_SLL;
            dec.a_reg_valid = 1'b0;
          end
          6'd2: begin  // srl
            dec.alu_op      = OP_SRL;
            dec.a_reg_valid = 1'b0;
          end
          6'd3: begin  // sra
            dec.alu_op      = OP_SRA;
            dec.a_reg_valid = 1'b0;
          end
          6'd4: dec.alu_op = OP_SLL;  // sllv
          6'd6: dec.alu_op = OP_SRL;  // srlv
          6'd7: dec.alu_op = OP_SRA;  // srav
          6'd8: begin  // jr
            dec.alu_inst       = 1'b0;
            dec.jmp_inst       = 1'b1;
            dec.b_reg_valid    = 1'b0;
            dec.dest_reg_valid = 1'b0;
          end
          6'd9: begin  // jalr links into rd
            dec.alu_inst    = 1'b0;
            dec.jmp_inst    = 1'b1;
            dec.b_reg_valid = 1'b0;
          end
          6'd32, 6'd33: dec.alu_op = OP_ADD;
          6'd34, 6'd35: dec.alu_op = OP_SUB;
          6'd36: dec.alu_op = OP_AND;
          6'd37: dec.alu_op = OP_OR;
          6'd38: dec.alu_op = OP_XOR;
          6'd39: dec.alu_op = OP_NOR;
          6'd42, 6'd43: begin  // slt, sltu
            dec.alu_op      = OP_SUB;
            dec.alu_res_sel = RES_SET;
            dec.alu_set_u   = inst.r_fmt.funct[0];
          end
          default: begin
            dec.alu_inst       = 1'b0;
            dec.a_reg_valid    = 1'b0;
            dec.b_reg_valid    = 1'b0;
            dec.dest_reg_valid = 1'b0;
            dec.illegal_inst   = 1'b1;
          end
        endcase
      end
      6'h02: begin  // j
        i_format           = 1'b0;
        dec.jmp_inst       = 1'b1;
        dec.dest_reg_valid = 1'b0;
      end
      6'h03: begin  // jal
        i_format     = 1'b0;
        dec.jmp_inst = 1'b1;
        dec.dest_reg = 5'd31;
      end
      6'h04, 6'h05, 6'h06, 6'h07: begin  // beq, bne, blez, bgtz
        imm_sext           = 1'b1;
        dec.jmp_inst       = 1'b1;
        dec.dest_reg_valid = 1'b0;
        case (inst.i_fmt.opc[1:0])
          2'd0: dec.jmp_cond = COND_EQ;
          2'd1: dec.jmp_cond = COND_NE;
          2'd2: dec.jmp_cond = COND_LE;
          default: dec.jmp_cond = COND_GT;
        endcase
      end
      6'h08, 6'h09: begin  // addi, addiu
        imm_sext        = 1'b1;
        dec.alu_inst    = 1'b1;
        dec.alu_op      = OP_ADD;
        dec.a_reg_valid = 1'b1;
      end
      6'h0a, 6'h0b: begin  // slti, sltiu
        imm_sext        = 1'b1;
        dec.alu_inst    = 1'b1;
        dec.alu_op      = OP_SUB;
        dec.alu_res_sel = RES_SET;
        dec.alu_set_u   = inst.i_fmt.opc[0];
        dec.a_reg_valid = 1'b1;
      end
      6'h0c, 6'h0d, 6'h0e: begin  // andi, ori, xori
        dec.alu_inst    = 1'b1;
        dec.a_reg_valid = 1'b1;
        case (inst.i_fmt.opc[1:0])
          2'd0: dec.alu_op = OP_AND;
          2'd1: dec.alu_op = OP_OR;
          default: dec.alu_op = OP_XOR;
        endcase
      end
      6'h0f: begin  // lui
        dec.alu_inst = 1'b1;
        dec.alu_op   = OP_LUI;
      end
      6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin  // lb lh lw lbu lhu
        imm_sext        = 1'b1;
        dec.alu_op      = OP_ADD;
        dec.load_inst   = 1'b1;
        dec.a_reg_valid = 1'b1;
        dec.ls_sext     = (inst.i_fmt.opc[2:0] == 3'd0) || (inst.i_fmt.opc[2:0] == 3'd1);
        case (inst.i_fmt.opc[1:0])
          2'd0: dec.ls_op = OP_LS_BYTE;
          2'd1: dec.ls_op = OP_LS_HALFWORD;
          default: dec.ls_op = OP_LS_WORD;
        endcase
      end
      6'h28, 6'h29, 6'h2b: begin  // sb sh sw
        imm_sext           = 1'b1;
        dec.alu_op         = OP_ADD;
        dec.store_inst     = 1'b1;
        dec.a_reg_valid    = 1'b1;
        dec.b_reg_valid    = 1'b1;
        dec.b_need_late    = 1'b1;  // store data used in mem only
        dec.dest_reg_valid = 1'b0;
        case (inst.i_fmt.opc[1:0])
          2'd0: dec.ls_op = OP_LS_BYTE;
          2'd1: dec.ls_op = OP_LS_HALFWORD;
          default: dec.ls_op = OP_LS_WORD;
        endcase
      end
      default: begin
        dec.dest_reg_valid = 1'b0;
        dec.illegal_inst   = 1'b1;
      end
    endcase

    dec.imm       = imm_sext ? {{16{inst.i_fmt.imm16[15]}}, inst.i_fmt.imm16}
                             : {16'd0, inst.i_fmt.imm16};
    dec.imm_valid = i_format;
  end

endmodule

`default_nettype wire

//--- src/hazard_unit.sv
`default_nettype none

module hazard_unit import pip_types_pkg::*; (
  input  decode_t  dec,
  input  dest_t    id_ex_dest,
  input  logic     id_ex_load,
  input  dest_t    ex_mem_dest,
  output fwd_sel_t fwd,
  output logic     stall
);

  logic a_match_id_ex;
  logic b_match_id_ex;
  logic a_match_ex_mem;
  logic b_match_ex_mem;

  assign a_match_id_ex  = dec.a_reg_valid && id_ex_dest.valid &&
                          (dec.a_reg == id_ex_dest.reg_num);
  assign b_match_id_ex  = dec.b_reg_valid && id_ex_dest.valid &&
                          (dec.b_reg == id_ex_dest.reg_num);
  assign a_match_ex_mem = dec.a_reg_valid && ex_mem_dest.valid &&
                          (dec.a_reg == ex_mem_dest.reg_num);
  assign b_match_ex_mem = dec.b_reg_valid && ex_mem_dest.valid &&
                          (dec.b_reg == ex_mem_dest.reg_num);

  // younger producer in id/ex takes priority
  always_comb begin
    if (a_match_id_ex)
      fwd.a_fwd = FWD_FROM_EXMEM;
    else if (a_match_ex_mem)
      fwd.a_fwd = FWD_FROM_MEMWB;
    else
      fwd.a_fwd = FWD_NONE;

    if (b_match_id_ex)
      fwd.b_fwd = id_ex_load ? FWD_FROM_MEMWB_LATE : FWD_FROM_EXMEM;
    else if (b_match_ex_mem)
      fwd.b_fwd = FWD_FROM_MEMWB;
    else
      fwd.b_fwd = FWD_NONE;
  end

  // load data not ready for ex, unless b is a late store operand
  assign stall = id_ex_load && (a_match_id_ex || (b_match_id_ex && !dec.b_need_late));

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none

module reg_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rd_addr1,
  input  logic [4:0]  rd_addr2,
  output logic [31:0] rd_data1,
  output logic [31:0] rd_data2,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data
);

  logic [31:0] regs [32];
  logic        wr_active;

  assign wr_active = wr_en && (wr_addr != 5'd0);  // r0 never written

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wr_active) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through so a same cycle writeback is seen in decode
  assign rd_data1 = (wr_active && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
  assign rd_data2 = (wr_active && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule

`default_nettype wire

//--- src/id_ex_reg.sv
`default_nettype none

module id_ex_reg import pip_types_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] pc,
  input  decode_t     dec,
  input  logic [31:0] a_data,
  input  logic [31:0] b_data,
  input  fwd_sel_t    fwd,
  input  logic        stall,
  output id_ex_t      id_ex
);

  id_ex_t nxt;

  always_comb begin
    nxt.pc             = pc;
    nxt.a_data         = a_data;
    nxt.b_data         = b_data;
    nxt.a_reg          = dec.a_reg;
    nxt.b_reg          = dec.b_reg;
    nxt.b_need_late    = dec.b_need_late;
    nxt.dest_reg       = dec.dest_reg;
    nxt.imm            = dec.imm;
    nxt.imm_valid      = dec.imm_valid;
    nxt.shamt          = dec.shamt;
    nxt.alu_op         = dec.alu_op;
    nxt.alu_res_sel    = dec.alu_res_sel;
    nxt.alu_set_u      = dec.alu_set_u;
    nxt.ls_op          = dec.ls_op;
    nxt.ls_sext        = dec.ls_sext;
    nxt.jmp_cond       = dec.jmp_cond;
    nxt.fwd            = fwd;
    // bubble keeps the data fields but kills every effect
    nxt.dest_reg_valid = dec.dest_reg_valid && !stall;
    nxt.alu_inst       = dec.alu_inst && !stall;
    nxt.load_inst      = dec.load_inst && !stall;
    nxt.store_inst     = dec.store_inst && !stall;
    nxt.jmp_inst       = dec.jmp_inst && !stall;
  end

  always_ff @(posedge clock) begin
    if (reset)
      id_ex <= '0;  // empty bubble
    else
      id_ex <= nxt;
  end

endmodule

`default_nettype wire

//--- src/id_stage.sv
`default_nettype none

module id_stage import pip_types_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] pc,
  input  inst_word_t  inst_word,
  input  dest_t       ex_mem_dest,
  input  logic        wb_we,
  input  logic [4:0]  wb_addr,
  input  logic [31:0] wb_data,
  output logic        stall,
  output id_ex_t      id_ex
);

  decode_t     dec;
  fwd_sel_t    fwd;
  dest_t       id_ex_dest;
  logic [31:0] rd_data1;
  logic [31:0] rd_data2;

  // instruction now in ex, fed back for hazard checks
  assign id_ex_dest.reg_num = id_ex.dest_reg;
  assign id_ex_dest.valid   = id_ex.dest_reg_valid;

  inst_decoder u_decoder (
    .inst (inst_word),
    .dec  (dec)
  );

  reg_file u_reg_file (
    .clock    (clock),
    .reset    (reset),
    .rd_addr1 (inst_word.r_fmt.rs),  // raw fields, valid bits gate usage later
    .rd_addr2 (inst_word.r_fmt.rt),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2),
    .wr_en    (wb_we),
    .wr_addr  (wb_addr),
    .wr_data  (wb_data)
  );

  hazard_unit u_hazard (
    .dec         (dec),
    .id_ex_dest  (id_ex_dest),
    .id_ex_load  (id_ex.load_inst),
    .ex_mem_dest (ex_mem_dest),
    .fwd         (fwd),
    .stall       (stall)
  );

  id_ex_reg u_id_ex_reg (
    .clock  (clock),
    .reset  (reset),
    .pc     (pc),
    .dec    (dec),
    .a_data (rd_data1),
    .b_data (rd_data2),
    .fwd    (fwd),
    .stall  (stall),
    .id_ex  (id_ex)
  );

endmodule

`default_nettype wire

//--- dv/id_stage_properties.sv
`default_nettype none

module id_stage_properties import pip_types_pkg::*; (
  input logic   clock,
  input logic   reset,
  input logic   stall,
  input id_ex_t id_ex
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled cycle must leave a bubble behind
  assert property (@(posedge clock) disable iff (reset)
    stall |=> !(id_ex.alu_inst || id_ex.load_inst || id_ex.store_inst ||
                id_ex.jmp_inst || id_ex.dest_reg_valid))
    else $error("stall did not insert a bubble into id_ex");

  assert property (@(posedge clock) disable iff (reset)
    !stall |=> !(id_ex.load_inst && id_ex.store_inst))
    else $error("id_ex marks an instruction as both load and store");

  assert property (@(posedge clock) disable iff (reset)
    !$isunknown({stall, id_ex}))
    else $error("unknown value on stall or id_ex");

endmodule

bind id_stage id_stage_properties props_i (
  .clock (clock),
  .reset (reset),
  .stall (stall),
  .id_ex (id_ex)
);

`default_nettype wire

//--- dv/tb_id_stage.sv
`default_nettype none

module tb_id_stage import pip_types_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [31:0] inst;
    dest_t       exm;
    alu_op_t     alu;
    logic [3:0]  flags;  // alu, load, store, jmp
    logic [4:0]  dest;
    logic        dv;
    logic [31:0] imm;
    logic        iv;
    fwd_t        af;
    fwd_t        bf;
    logic        st;
  } row_t;

  localparam dest_t no_exm = '0;
  localparam fwd_t f_none = FWD_NONE;
  localparam fwd_t f_exm  = FWD_FROM_EXMEM;
  localparam fwd_t f_mwb  = FWD_FROM_MEMWB;
  localparam fwd_t f_late = FWD_FROM_MEMWB_LATE;

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] pc;
  inst_word_t  inst_word;
  dest_t       ex_mem_dest;
  logic        wb_we;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        stall;
  id_ex_t      id_ex;

  logic [31:0] model [32];
  row_t        rows [$];
  int          errors = 0;
  int          seed = 12764;

  id_stage dut_i (.*);

  always #50 clock = ~clock;

  initial begin  // watchdog
    #1ms;
    $display("simulation ran too long, watchdog expired");
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] r_inst(input int rs, input int rt, input int rd,
                                         input int sh, input int fn);
    r_inst = {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
  endfunction

  function automatic logic [31:0] i_inst(input int opc, input int rs, input int rt,
                                         input logic [15:0] imm);
    i_inst = {6'(opc), 5'(rs), 5'(rt), imm};
  endfunction

  function automatic logic [3:0] class_flags(input id_ex_t x);
    class_flags = {x.alu_inst, x.load_inst, x.store_inst, x.jmp_inst};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input logic [31:0] inst, input dest_t exm, input alu_op_t alu,
                         input logic [3:0] flags, input int dest, input logic dv,
                         input logic [31:0] imm, input logic iv, input fwd_t af,
                         input fwd_t bf, input logic st);
    rows.push_back({inst, exm, alu, flags, 5'(dest), dv, imm, iv, af, bf, st});
  endtask

  // called on a falling edge, returns on the falling edge after capture
  task automatic apply_row(input row_t r, input logic [31:0] row_pc);
    int wait_cnt;
    logic [4:0] rs;
    logic [4:0] rt;
    rs = r.inst[25:21];
    rt = r.inst[20:16];
    pc = row_pc;
    inst_word = r.inst;
    ex_mem_dest = r.exm;
    #10;
    check("stall", stall, r.st);
    if (stall) begin
      @(posedge clock);
      @(negedge clock);
      check("bubble class flags", class_flags(id_ex), 4'b0);
      check("bubble dest_reg_valid", id_ex.dest_reg_valid, 1'b0);
      wait_cnt = 0;
      while (stall && wait_cnt < 4) begin
        @(negedge clock);
        wait_cnt++;
      end
      if (stall) begin
        errors++;
        $display("stall stayed high after the load left ID/EX");
      end
    end
    @(posedge clock);
    @(negedge clock);
    check("pc", id_ex.pc, row_pc);
    check("alu_op", 32'(id_ex.alu_op), 32'(r.alu));
    check("class flags", class_flags(id_ex), r.flags);
    check("dest_reg_valid", id_ex.dest_reg_valid, r.dv);
    if (r.dv)
      check("dest_reg", id_ex.dest_reg, r.dest);
    check("imm_valid", id_ex.imm_valid, r.iv);
    if (r.iv)
      check("imm", id_ex.imm, r.imm);
    check("a_fwd", 32'(id_ex.fwd.a_fwd), 32'(r.af));
    check("b_fwd", 32'(id_ex.fwd.b_fwd), 32'(r.bf));
    check("a_data", id_ex.a_data, model[rs]);
    check("b_data", id_ex.b_data, model[rt]);
  endtask

  initial begin
    pc = '0;
    inst_word = 32'h8c21_0000;  // lw r1 reading its own destination
    ex_mem_dest = no_exm;
    wb_we = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    for (int i = 0; i < 32; i++)
      model[i] = '0;

    repeat (16) @(negedge clock);
    reset = 1'b0;
    check("reset class flags", class_flags(id_ex), 4'b0);
    check("reset stall", stall, 1'b0);
    inst_word = 32'h0800_0000;  // j 0, no destination

    for (int i = 0; i < 32; i++) begin  // preload through writeback
      wb_we = 1'b1;
      wb_addr = 5'(i);
      wb_data = $random(seed);
      model[i] = (i == 0) ? 32'd0 : wb_data;  // r0 ignores writes
      @(negedge clock);
    end
    wb_we = 1'b0;

    add_row(r_inst(1, 2, 3, 0, 32), no_exm, OP_ADD, 4'b1000, 3, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(3, 5, 4, 0, 34), {5'd5, 1'b1}, OP_SUB, 4'b1000, 4, 1, 0, 0, f_exm, f_mwb, 0);
    add_row(r_inst(7, 4, 6, 0, 36), {5'd4, 1'b1}, OP_AND, 4'b1000, 6, 1, 0, 0, f_none, f_exm, 0);
    add_row(r_inst(8, 9, 20, 0, 37), {5'd8, 1'b1}, OP_OR, 4'b1000, 20, 1, 0, 0, f_mwb, f_none, 0);
    add_row(r_inst(10, 11, 21, 0, 38), no_exm, OP_XOR, 4'b1000, 21, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(12, 13, 22, 0, 39), no_exm, OP_NOR, 4'b1000, 22, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(1, 2, 23, 0, 42), no_exm, OP_SUB, 4'b1000, 23, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(3, 4, 24, 0, 43), no_exm, OP_SUB, 4'b1000, 24, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(0, 2, 25, 4, 0), no_exm, OP_SLL, 4'b1000, 25, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(0, 2, 26, 3, 2), no_exm, OP_SRL, 4'b1000, 26, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(0, 2, 27, 1, 3), no_exm, OP_SRA, 4'b1000, 27, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(1, 2, 28, 0, 4), no_exm, OP_SLL, 4'b1000, 28, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(1, 2, 29, 0, 6), no_exm, OP_SRL, 4'b1000, 29, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(1, 2, 30, 0, 7), no_exm, OP_SRA, 4'b1000, 30, 1, 0, 0, f_none, f_none, 0);
    add_row(r_inst(31, 0, 0, 0, 8), no_exm, OP_PASS_A, 4'b0001, 0, 0, 0, 0, f_none, f_none, 0);
    add_row(r_inst(1, 0, 31, 0, 9), no_exm, OP_PASS_A, 4'b0001, 31, 1, 0, 0, f_none, f_none, 0);
    add_row(32'h0800_0040, no_exm, OP_PASS_A, 4'b0001, 0, 0, 0, 0, f_none, f_none, 0);
    add_row(32'h0c00_0080, no_exm, OP_PASS_A, 4'b0001, 31, 1, 0, 0, f_none, f_none, 0);
    add_row(i_inst(4, 1, 2, 16'hfffc), no_exm, OP_PASS_A, 4'b0001, 0, 0, 32'hffff_fffc, 1,
            f_none, f_none, 0);
    add_row(i_inst(5, 1, 2, 16'h0010), no_exm, OP_PASS_A, 4'b0001, 0, 0, 32'h10, 1,
            f_none, f_none, 0);
    add_row(i_inst(6, 3, 0, 16'h8000), no_exm, OP_PASS_A, 4'b0001, 0, 0, 32'hffff_8000, 1,
            f_none, f_none, 0);
    add_row(i_inst(7, 4, 0, 16'h0001), no_exm, OP_PASS_A, 4'b0001, 0, 0, 32'h1, 1,
            f_none, f_none, 0);
    add_row(i_inst(8, 1, 20, 16'h8001), no_exm, OP_ADD, 4'b1000, 20, 1, 32'hffff_8001, 1,
            f_none, f_none, 0);
    add_row(i_inst(9, 20, 21, 16'h0005), {5'd20, 1'b1}, OP_ADD, 4'b1000, 21, 1, 32'h5, 1,
            f_exm, f_none, 0);
    add_row(i_inst(10, 2, 22, 16'hffff), no_exm, OP_SUB, 4'b1000, 22, 1, 32'hffff_ffff, 1,
            f_none, f_none, 0);
    add_row(i_inst(11, 1, 23, 16'h7fff), no_exm, OP_SUB, 4'b1000, 23, 1, 32'h7fff, 1,
            f_none, f_none, 0);
    add_row(i_inst(12, 1, 24, 16'h8000), no_exm, OP_AND, 4'b1000, 24, 1, 32'h8000, 1,
            f_none, f_none, 0);
    add_row(i_inst(13, 2, 3, 16'hf0f0), no_exm, OP_OR, 4'b1000, 3, 1, 32'hf0f0, 1,
            f_none, f_none, 0);
    add_row(i_inst(14, 4, 5, 16'hffff), no_exm, OP_XOR, 4'b1000, 5, 1, 32'hffff, 1,
            f_none, f_none, 0);
    add_row(i_inst(15, 0, 25, 16'h1234), no_exm, OP_LUI, 4'b1000, 25, 1, 32'h1234, 1,
            f_none, f_none, 0);
    add_row(i_inst(32, 1, 26, 16'hfff0), no_exm, OP_ADD, 4'b0100, 26, 1, 32'hffff_fff0, 1,
            f_none, f_none, 0);
    add_row(i_inst(33, 2, 27, 16'h0004), no_exm, OP_ADD, 4'b0100, 27, 1, 32'h4, 1,
            f_none, f_none, 0);
    add_row(i_inst(36, 3, 28, 16'h0008), no_exm, OP_ADD, 4'b0100, 28, 1, 32'h8, 1,
            f_none, f_none, 0);
    add_row(i_inst(37, 4, 29, 16'h8002), no_exm, OP_ADD, 4'b0100, 29, 1, 32'hffff_8002, 1,
            f_none, f_none, 0);
    add_row(i_inst(35, 5, 30, 16'h0008), no_exm, OP_ADD, 4'b0100, 30, 1, 32'h8, 1,
            f_none, f_none, 0);
    add_row(i_inst(40, 6, 7, 16'hfffe), no_exm, OP_ADD, 4'b0010, 0, 0, 32'hffff_fffe, 1,
            f_none, f_none, 0);
    add_row(i_inst(41, 8, 9, 16'h0002), no_exm, OP_ADD, 4'b0010, 0, 0, 32'h2, 1,
            f_none, f_none, 0);
    add_row(i_inst(43, 10, 11, 16'h000c), no_exm, OP_ADD, 4'b0010, 0, 0, 32'hc, 1,
            f_none, f_none, 0);
    // load-use on rs stalls once
    add_row(i_inst(35, 1, 12, 16'h0000), no_exm, OP_ADD, 4'b0100, 12, 1, 32'h0, 1,
            f_none, f_none, 0);
    add_row(r_inst(12, 2, 13, 0, 32), {5'd12, 1'b1}, OP_ADD, 4'b1000, 13, 1, 0, 0,
            f_mwb, f_none, 1);
    // store data from a load goes late
    add_row(i_inst(35, 1, 14, 16'h0000), no_exm, OP_ADD, 4'b0100, 14, 1, 32'h0, 1,
            f_none, f_none, 0);
    add_row(i_inst(43, 2, 14, 16'h0004), no_exm, OP_ADD, 4'b0010, 0, 0, 32'h4, 1,
            f_none, f_late, 0);
    add_row(i_inst(35, 1, 15, 16'h0000), no_exm, OP_ADD, 4'b0100, 15, 1, 32'h0, 1,
            f_none, f_none, 0);
    add_row(i_inst(43, 15, 3, 16'h0000), {5'd15, 1'b1}, OP_ADD, 4'b0010, 0, 0, 32'h0, 1,
            f_mwb, f_none, 1);
    add_row(r_inst(1, 2, 5, 0, 1), no_exm, OP_PASS_A, 4'b0000, 0, 0, 0, 0, f_none, f_none, 0);

    foreach (rows[i])
      apply_row(rows[i], 32'h0040_0000 + 32'(i) * 4);

    // writeback in the same cycle as the read
    wb_we = 1'b1;
    wb_addr = 5'd5;
    wb_data = model[5] ^ 32'h5a5a_a5a5;
    model[5] = wb_data;
    add_row(r_inst(5, 6, 1, 0, 32), no_exm, OP_ADD, 4'b1000, 1, 1, 0, 0, f_none, f_none, 0);
    apply_row(rows[rows.size() - 1], 32'h0040_1000);
    wb_we = 1'b0;

    $display("checks done, %0d errors", errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
src/pip_types_pkg.sv
src/inst_decoder.sv
src/hazard_unit.sv
src/reg_file.sv
src/id_ex_reg.sv
src/id_stage.sv
dv/id_stage_properties.sv
dv/tb_id_stage.sv

//--- Makefile
SRCS := $(wildcard src/*.sv dv/*.sv)

.PHONY: run clean

obj_dir/Vtb_id_stage: $(SRCS) files.f
	verilator --binary --assert --timing --timescale 1ns/1ps -j 0 \
		-f files.f --top-module tb_id_stage

run: obj_dir/Vtb_id_stage
	./obj_dir/Vtb_id_stage 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
